// File: compile.f
+incdir+include
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/flag_if.sv
logic/instr_decode.sv
logic/flag_compare.sv
logic/branch_ctrl.sv
logic/pc_unit.sv
logic/branch_front.sv
tests/tb_clock.sv
tests/tb_branch_front.sv

// File: include/branch_cfg.svh
`ifndef BRANCH_CFG_SVH
`define BRANCH_CFG_SVH

// operand width of the compare path
`define BR_DATA_WIDTH 32

// fetch address width
`define BR_PC_WIDTH 32

// first fetch address out of reset
`define BR_RESET_PC 32'h0000_0000

// float compare cycles, launch to flag strobe
`define BR_FCMP_LATENCY 3

`endif

// File: logic/branch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module branch_ctrl (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               ex_busy,
    input  wire logic               mem_busy,
    input  wire logic               branch_en,
    input  isa_pkg::branch_op_e     branch_op,
    flag_if.consumer                flags,
    output logic                    if_de_stall,
    output pipe_pkg::next_pc_sel_e  next_pc_select
);
    import isa_pkg::*;
    import pipe_pkg::*;

    br_state_e  state;
    br_state_e  state_next;
    cond_flag_e flag;
    logic       busy;
    logic       flag_write;

    assign busy       = ex_busy || mem_busy;
    assign flag_write = flags.int_flag_en || flags.float_flag_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            flag  <= flag_eq;
        end else begin
            state <= state_next;
            // integer wins if both ever arrive together
            if (flags.int_flag_en)
                flag <= flags.int_flag;
            else if (flags.float_flag_en)
                flag <= flags.float_flag;
        end
    end

    // condition check against the latched flag
    always_comb begin
        next_pc_select = sel_seq;
        if (branch_en) begin
            case (branch_op)
                op_be:   next_pc_select = (flag[1] == 1'b0) ? sel_offset : sel_seq;
                op_bne:  next_pc_select = (flag[1] == 1'b1) ? sel_offset : sel_seq;
                op_bl:   next_pc_select = (flag == flag_lt) ? sel_offset : sel_seq;
                op_bge:  next_pc_select = (flag == flag_lt) ? sel_seq : sel_offset;
                op_bg:   next_pc_select = (flag == flag_gt) ? sel_offset : sel_seq;
                op_ble:  next_pc_select = (flag == flag_gt) ? sel_seq : sel_offset;
                op_jmp:  next_pc_select = sel_offset;
                default: next_pc_select = sel_link;
            endcase
        end
    end

    always_comb begin
        state_next  = state;
        // later stages busy always holds fetch and decode
        if_de_stall = busy;

        case (state)
            st_idle: begin
                if (branch_en) begin
                    if (busy) begin
                        state_next  = st_waiting;
                        if_de_stall = 1'b1;
                    end else begin
                        // a flag being written this cycle is not yet usable
                        if_de_stall = flag_write;
                    end
                end
            end

            st_waiting: begin
                if (!branch_en) begin
                    state_next = st_idle;
                end else if (!busy) begin
                    state_next = st_idle;
                    // ret does not look at the flag
                    if (branch_op == op_ret)
                        if_de_stall = 1'b0;
                    else
                        if_de_stall = flag_write;
                end
            end

            default: state_next = st_idle;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/branch_front.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_cfg.svh"

module branch_front (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [31:0]                instr,
    input  wire logic                       instr_valid,
    input  wire logic [`BR_DATA_WIDTH-1:0]  op_a,
    input  wire logic [`BR_DATA_WIDTH-1:0]  op_b,
    input  wire logic [`BR_PC_WIDTH-1:0]    link_value,
    input  wire logic                       mem_busy,
    output logic [`BR_PC_WIDTH-1:0]         pc,
    output logic                            if_de_stall,
    output logic                            ex_busy
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic                       advance;
    logic                       branch_en;
    branch_op_e                 branch_op;
    logic signed [26:0]         branch_offset;
    logic                       cmp_launch;
    logic                       cmp_is_float;
    logic [`BR_DATA_WIDTH-1:0]  cmp_a;
    logic [`BR_DATA_WIDTH-1:0]  cmp_b;
    next_pc_sel_e               next_pc_select;

    flag_if flags ();

    // decode accepts on the same condition that moves the pc
    assign advance = instr_valid && !if_de_stall;

    instr_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr         (instr),
        .instr_valid   (instr_valid),
        .stall         (if_de_stall),
        .op_a          (op_a),
        .op_b          (op_b),
        .branch_en     (branch_en),
        .branch_op     (branch_op),
        .branch_offset (branch_offset),
        .cmp_launch    (cmp_launch),
        .cmp_is_float  (cmp_is_float),
        .cmp_a         (cmp_a),
        .cmp_b         (cmp_b)
    );

    flag_compare u_compare (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmp_launch   (cmp_launch),
        .cmp_is_float (cmp_is_float),
        .cmp_a        (cmp_a),
        .cmp_b        (cmp_b),
        .ex_busy      (ex_busy),
        .flags        (flags.producer)
    );

    branch_ctrl u_branch_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_busy        (ex_busy),
        .mem_busy       (mem_busy),
        .branch_en      (branch_en),
        .branch_op      (branch_op),
        .flags          (flags.consumer),
        .if_de_stall    (if_de_stall),
        .next_pc_select (next_pc_select)
    );

    pc_unit u_pc (
        .clk            (clk),
        .rst_n          (rst_n),
        .advance        (advance),
        .branch_en      (branch_en),
        .next_pc_select (next_pc_select),
        .branch_offset  (branch_offset),
        .link_value     (link_value),
        .pc             (pc)
    );

endmodule

`default_nettype wire

// File: logic/flag_compare.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_cfg.svh"

module flag_compare (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       cmp_launch,
    input  wire logic                       cmp_is_float,
    input  wire logic [`BR_DATA_WIDTH-1:0]  cmp_a,
    input  wire logic [`BR_DATA_WIDTH-1:0]  cmp_b,
    output logic                            ex_busy,
    flag_if.producer                        flags
);
    import pipe_pkg::*;

    localparam int W     = `BR_DATA_WIDTH;
    localparam int CNT_W = $clog2(`BR_FCMP_LATENCY + 1);

    logic [CNT_W-1:0] fcmp_count;
    logic             float_launch;
    cond_flag_e       float_flag_q;

    function automatic cond_flag_e int_compare(input logic signed [W-1:0] a,
                                               input logic signed [W-1:0] b);
        if (a == b)
            return flag_eq;
        return (a > b) ? flag_gt : flag_lt;
    endfunction

    // sign and magnitude only, nan patterns fall through as ordinary values
    function automatic cond_flag_e float_compare(input logic [W-1:0] a,
                                                 input logic [W-1:0] b);
        logic           a_neg;
        logic           b_neg;
        logic [W-2:0]   a_mag;
        logic [W-2:0]   b_mag;
        a_neg = a[W-1];
        b_neg = b[W-1];
        a_mag = a[W-2:0];
        b_mag = b[W-2:0];
        // +0 and -0 are equal
        if (a_mag == '0 && b_mag == '0)
            return flag_eq;
        if (a_neg != b_neg)
            return a_neg ? flag_lt : flag_gt;
        if (a_mag == b_mag)
            return flag_eq;
        if (a_mag > b_mag)
            return a_neg ? flag_lt : flag_gt;
        return a_neg ? flag_gt : flag_lt;
    endfunction

    assign float_launch = cmp_launch && cmp_is_float;

    // integer result is ready in the launch cycle itself
    assign flags.int_flag    = int_compare(cmp_a, cmp_b);
    assign flags.int_flag_en = cmp_launch && !cmp_is_float;

    // launch cycle counts as the first of the latency window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fcmp_count <= '0;
        end else if (float_launch) begin
            fcmp_count <= CNT_W'(`BR_FCMP_LATENCY - 1);
        end else if (fcmp_count != '0) begin
            fcmp_count <= fcmp_count - 1'b1;
        end
    end

    // result is taken at launch so later operand changes do not matter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            float_flag_q <= flag_eq;
        else if (float_launch)
            float_flag_q <= float_compare(cmp_a, cmp_b);
    end

    assign ex_busy             = float_launch || (fcmp_count > CNT_W'(1));
    assign flags.float_flag    = float_flag_q;
    assign flags.float_flag_en = (fcmp_count == CNT_W'(1));

endmodule

`default_nettype wire

// File: logic/flag_if.sv
`timescale 1ns/1ns
`default_nettype none

interface flag_if;
    import pipe_pkg::*;

    cond_flag_e int_flag;
    cond_flag_e float_flag;
    // one-cycle strobes, never high together
    logic       int_flag_en;
    logic       float_flag_en;

    modport producer (
        output int_flag, float_flag, int_flag_en, float_flag_en
    );

    modport consumer (
        input int_flag, float_flag, int_flag_en, float_flag_en
    );

endinterface

`default_nettype wire

// File: logic/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_cfg.svh"

module instr_decode (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  isa_pkg::instr_word_u            instr,
    input  wire logic                       instr_valid,
    input  wire logic                       stall,
    input  wire logic [`BR_DATA_WIDTH-1:0]  op_a,
    input  wire logic [`BR_DATA_WIDTH-1:0]  op_b,
    output logic                            branch_en,
    output isa_pkg::branch_op_e             branch_op,
    output logic signed [26:0]              branch_offset,
    output logic                            cmp_launch,
    output logic                            cmp_is_float,
    output logic [`BR_DATA_WIDTH-1:0]       cmp_a,
    output logic [`BR_DATA_WIDTH-1:0]       cmp_b
);
    import isa_pkg::*;

    logic accept;
    logic is_cmp;

    assign accept = instr_valid && !stall;
    // class sits in the same bits of both views
    assign is_cmp = (instr.cmp.cls == cls_cmp);

    // branch request stays up while the word is held in decode
    assign branch_en     = instr_valid && (instr.br.cls == cls_branch);
    assign branch_op     = instr.br.op;
    assign branch_offset = instr.br.offset;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmp_launch   <= 1'b0;
            cmp_is_float <= 1'b0;
        end else begin
            cmp_launch <= accept && is_cmp;
            if (accept && is_cmp)
                cmp_is_float <= instr.cmp.is_float;
        end
    end

    // operands follow the compare into execute
    always_ff @(posedge clk) begin
        if (accept && is_cmp) begin
            cmp_a <= op_a;
            cmp_b <= op_b;
        end
    end

endmodule

`default_nettype wire

// File: logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // top two bits of every instruction word
    typedef enum logic [1:0] {
        cls_alu    = 2'b00,
        cls_cmp    = 2'b01,
        cls_branch = 2'b10,
        cls_other  = 2'b11
    } instr_class_e;

    typedef enum logic [2:0] {
        op_be  = 3'b000,
        op_bne = 3'b001,
        op_bl  = 3'b010,
        op_bge = 3'b011,
        op_bg  = 3'b100,
        op_ble = 3'b101,
        op_jmp = 3'b110,
        op_ret = 3'b111
    } branch_op_e;

    // branch layout, offset is a signed byte distance from pc + 4
    typedef struct packed {
        instr_class_e      cls;
        branch_op_e        op;
        logic signed [26:0] offset;
    } branch_view_t;

    // compare layout, operands come from the register file ports
    typedef struct packed {
        instr_class_e cls;
        logic         is_float;
        logic [28:0]  rsvd;
    } cmp_view_t;

    typedef union packed {
        branch_view_t br;
        cmp_view_t    cmp;
    } instr_word_u;

endpackage

`default_nettype wire

// File: logic/pc_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_cfg.svh"

module pc_unit (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       advance,
    input  wire logic                       branch_en,
    input  pipe_pkg::next_pc_sel_e          next_pc_select,
    input  wire logic signed [26:0]         branch_offset,
    input  wire logic [`BR_PC_WIDTH-1:0]    link_value,
    output logic [`BR_PC_WIDTH-1:0]         pc
);
    import pipe_pkg::*;

    localparam int PC_W = `BR_PC_WIDTH;

    next_pc_sel_e    sel;
    logic [PC_W-1:0] pc_plus4;
    logic [PC_W-1:0] offset_ext;
    logic [PC_W-1:0] pc_next;

    // non-branch words always fall through
    assign sel        = branch_en ? next_pc_select : sel_seq;
    assign pc_plus4   = pc + PC_W'(4);
    assign offset_ext = {{(PC_W - 27){branch_offset[26]}}, branch_offset};

    always_comb begin
        case (sel)
            sel_offset: pc_next = pc_plus4 + offset_ext;
            sel_link:   pc_next = link_value;
            default:    pc_next = pc_plus4;
        endcase
    end

    // pc holds whenever decode does not accept
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= PC_W'(`BR_RESET_PC);
        else if (advance)
            pc <= pc_next;
    end

endmodule

`default_nettype wire

// File: logic/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // pc source picked by the branch controller
    typedef enum logic [1:0] {
        sel_seq    = 2'b00,
        sel_offset = 2'b10,
        sel_link   = 2'b11
    } next_pc_sel_e;

    // bit 1 set means not equal, bit 0 then tells lt from gt
    typedef enum logic [1:0] {
        flag_eq = 2'b00,
        flag_gt = 2'b10,
        flag_lt = 2'b11
    } cond_flag_e;

    typedef enum logic {
        st_idle    = 1'b0,
        st_waiting = 1'b1
    } br_state_e;

endpackage

`default_nettype wire

// File: tests/tb_branch_front.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_cfg.svh"

module tb_branch_front;
    import isa_pkg::*;
    import pipe_pkg::*;

    // the tests need about 80 cycles, this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 400;

    logic                       clk;
    logic                       rst_n;
    logic [31:0]                instr;
    logic                       instr_valid;
    logic [`BR_DATA_WIDTH-1:0]  op_a;
    logic [`BR_DATA_WIDTH-1:0]  op_b;
    logic [`BR_PC_WIDTH-1:0]    link_value;
    logic                       mem_busy;
    logic [`BR_PC_WIDTH-1:0]    pc;
    logic                       if_de_stall;
    logic                       ex_busy;

    integer                     seed;
    int                         errors;
    int                         checks;
    int                         cycle_count;
    int                         busy_cycles;
    int                         last_stalls;
    cond_flag_e                 exp_flag;
    logic [`BR_PC_WIDTH-1:0]    exp_pc;

    tb_clock u_clock (
        .clk (clk)
    );

    branch_front u_branch_front (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .op_a        (op_a),
        .op_b        (op_b),
        .link_value  (link_value),
        .mem_busy    (mem_busy),
        .pc          (pc),
        .if_de_stall (if_de_stall),
        .ex_busy     (ex_busy)
    );

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL at %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
        end
    endtask

    // three-way ordering of two signed keys
    function automatic cond_flag_e order_flag(input logic signed [33:0] a,
                                              input logic signed [33:0] b);
        if (a == b)
            return flag_eq;
        else if (a > b)
            return flag_gt;
        else
            return flag_lt;
    endfunction

    // float bits to an ordered key, so -0 and +0 both land on 0
    function automatic logic signed [33:0] float_key(input logic [31:0] f);
        logic signed [33:0] mag;
        mag = {3'b000, f[30:0]};
        return f[31] ? -mag : mag;
    endfunction

    function automatic logic branch_taken(input branch_op_e op, input cond_flag_e flag);
        case (op)
            op_be:   return flag[1] == 1'b0;
            op_bne:  return flag[1] == 1'b1;
            op_bl:   return flag == flag_lt;
            op_bge:  return flag != flag_lt;
            op_bg:   return flag == flag_gt;
            op_ble:  return flag != flag_gt;
            op_jmp:  return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // small word-aligned offset, either sign
    function automatic logic [26:0] random_offset();
        logic [31:0] r;
        r = $random(seed);
        return {{17{r[9]}}, r[9:2], 2'b00};
    endfunction

    // present one word and hold it until decode accepts it
    task automatic send_word(input logic [31:0] word);
        logic [`BR_PC_WIDTH-1:0] pc_before;
        logic                    stalled;
        pc_before   = pc;
        last_stalls = 0;
        stalled     = 1'b1;
        instr       = word;
        instr_valid = 1'b1;
        while (stalled) begin
            @(negedge clk);
            stalled = if_de_stall;
            if (stalled) begin
                last_stalls++;
                check_value(pc, pc_before, "pc moved during stall");
            end
            @(posedge clk);
            #10;
        end
        instr_valid = 1'b0;
    endtask

    task automatic send_alu();
        logic [31:0] r;
        r = $random(seed);
        send_word({cls_alu, r[29:0]});
        exp_pc = exp_pc + 4;
        check_value(pc, exp_pc, "pc after alu word");
    endtask

    task automatic send_cmp(input logic is_float, input logic [31:0] a, input logic [31:0] b);
        op_a = a;
        op_b = b;
        busy_cycles = 0;
        send_word({cls_cmp, is_float, 29'h0});
        if (is_float)
            exp_flag = order_flag(float_key(a), float_key(b));
        else
            exp_flag = order_flag({{2{a[31]}}, a}, {{2{b[31]}}, b});
        exp_pc = exp_pc + 4;
        check_value(pc, exp_pc, "pc after compare");
    endtask

    task automatic send_branch(input branch_op_e op, input logic [26:0] offset);
        logic [`BR_PC_WIDTH-1:0] target;
        if (op == op_ret)
            target = link_value;
        else if (branch_taken(op, exp_flag))
            target = exp_pc + 4 + {{(`BR_PC_WIDTH - 27){offset[26]}}, offset};
        else
            target = exp_pc + 4;
        send_word({cls_branch, op, offset});
        exp_pc = target;
        check_value(pc, exp_pc, $sformatf("pc after %s on flag %s", op.name(), exp_flag.name()));
    endtask

    task automatic test_reset_and_sequence();
        exp_pc   = `BR_RESET_PC;
        exp_flag = flag_eq;
        check_value(pc, `BR_RESET_PC, "pc after reset");
        check_value(if_de_stall, 1'b0, "stall after reset");
        repeat (3) send_alu();
    endtask

    // last two rounds use equal operands
    task automatic test_int_branches();
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < 8; i++) begin
            a = $random(seed);
            b = (i >= 6) ? a : $random(seed);
            send_cmp(1'b0, a, b);
            send_branch(branch_op_e'(i % 6), random_offset());
            check_value(last_stalls, 1, "stall cycles after integer compare");
        end
    endtask

    task automatic test_jmp_ret();
        send_branch(op_jmp, 27'h40);
        check_value(last_stalls, 0, "stall cycles for jmp");
        send_branch(op_jmp, 27'h7ff_ffe0);
        link_value = $random(seed) & 32'hffff_fffc;
        send_branch(op_ret, 27'h0);
    endtask

    // the last pair is +0 against -0
    task automatic test_float_branches();
        logic [31:0] a;
        logic [31:0] b;
        branch_op_e  op;
        for (int i = 0; i < 4; i++) begin
            a  = (i == 3) ? 32'h0000_0000 : $random(seed);
            b  = (i == 3) ? 32'h8000_0000 : $random(seed);
            op = (i == 3) ? op_be : branch_op_e'(i + 2);
            send_cmp(1'b1, a, b);
            send_branch(op, random_offset());
            check_value(busy_cycles, `BR_FCMP_LATENCY - 1, "ex_busy cycles for float compare");
            check_value(last_stalls, `BR_FCMP_LATENCY, "stall cycles after float compare");
        end
    endtask

    task automatic test_mem_busy();
        send_cmp(1'b0, $random(seed), $random(seed));
        send_alu();
        mem_busy = 1'b1;
        fork
            send_branch(op_bne, random_offset());
            begin
                repeat (4) @(posedge clk);
                #10;
                mem_busy = 1'b0;
            end
        join
        check_value(last_stalls, 4, "stall cycles under mem_busy");
    endtask

    always @(negedge clk) begin
        if (ex_busy === 1'b1)
            busy_cycles++;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        seed        = 32'h0a28_7e3c;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        busy_cycles = 0;
        last_stalls = 0;
        exp_flag    = flag_eq;
        exp_pc      = `BR_RESET_PC;
        rst_n       = 1'b0;
        instr       = 32'h0;
        instr_valid = 1'b0;
        op_a        = '0;
        op_b        = '0;
        link_value  = '0;
        mem_busy    = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;

        test_reset_and_sequence();
        test_int_branches();
        test_jmp_ret();
        test_float_branches();
        test_mem_busy();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD = 50
) (
    output logic clk
);

    // 100 ns period, first rising edge at 50 ns
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire
